// File: design/frame_capture.sv
`timescale 1ns/1ps

// Accepts a send edge, latches the packet inputs and builds both headers
// The IP checksum is left at zero here and filled in by the next stage
module frame_capture #(
    parameter int DATA_BYTES = 1
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [8*DATA_BYTES-1:0] data,
    input  logic [31:0]             src_ip,
    input  logic [31:0]             dest_ip,
    input  logic [15:0]             src_port,
    input  logic [15:0]             dest_port,
    input  logic                    send,
    input  logic                    gap_done,
    output logic                    ready,
    frame_if.src                    raw
);

    // Length fields count bytes from the start of their own header
    localparam logic [15:0] TOTAL_LENGTH =
        16'(udp_ip_pkg::IP_HEADER_BYTES + udp_ip_pkg::UDP_HEADER_BYTES + DATA_BYTES);
    localparam logic [15:0] UDP_LENGTH = 16'(udp_ip_pkg::UDP_HEADER_BYTES + DATA_BYTES);

    logic send_prev;
    logic send_edge;
    logic accept;

    assign send_edge = send & ~send_prev;
    // Edges that arrive while a packet is still in flight are dropped
    assign accept    = send_edge & ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            // Treat send as already high so that a level held through reset is no edge
            send_prev <= 1'b1;
            ready     <= 1'b1;
            raw.valid <= 1'b0;
        end else begin
            send_prev <= send;
            raw.valid <= accept;
            if (accept) begin
                ready <= 1'b0;
            end else if (gap_done) begin
                // The serializer has finished the packet and its gap
                ready <= 1'b1;
            end
        end
    end

    // Header and payload registers, loaded only on an accepted edge
    always_ff @(posedge clk) begin
        if (accept) begin
            raw.ip_header.fields.version         <= udp_ip_pkg::IP_VERSION;
            raw.ip_header.fields.ihl             <= udp_ip_pkg::IP_IHL;
            raw.ip_header.fields.type_of_service <= udp_ip_pkg::IP_TOS;
            raw.ip_header.fields.total_length    <= TOTAL_LENGTH;
            raw.ip_header.fields.identification  <= udp_ip_pkg::IP_IDENT;
            raw.ip_header.fields.flags           <= udp_ip_pkg::IP_FLAGS;
            raw.ip_header.fields.fragment_offset <= udp_ip_pkg::IP_FRAG_OFFSET;
            raw.ip_header.fields.time_to_live    <= udp_ip_pkg::IP_TTL;
            raw.ip_header.fields.protocol        <= udp_ip_pkg::IP_PROTOCOL_UDP;
            // Must be zero while the checksum stage sums the header
            raw.ip_header.fields.header_checksum <= 16'h0000;
            raw.ip_header.fields.src_ip          <= src_ip;
            raw.ip_header.fields.dest_ip         <= dest_ip;

            raw.udp_header.src_port  <= src_port;
            raw.udp_header.dest_port <= dest_port;
            raw.udp_header.length    <= UDP_LENGTH;
            // A zero UDP checksum means none was computed
            raw.udp_header.checksum  <= 16'h0000;

            raw.payload <= data;
        end
    end

    // A packet leaves this stage only right after ready dropped for it
    assert property (@(posedge clk) disable iff (reset) raw.valid |-> $fell(ready))
        else $error("raw frame valid without a falling ready in the cycle before");

endmodule

// File: design/frame_if.sv
`timescale 1ns/1ps

// Carries one complete packet between pipeline stages
// The producer pulses valid for one cycle and holds the data until the next pulse
interface frame_if #(
    parameter int DATA_BYTES = 1
);

    logic                         valid;
    udp_ip_pkg::ip_header_u       ip_header;
    udp_ip_pkg::udp_header_t      udp_header;
    // The most significant byte is the first payload byte on the wire
    logic [8*DATA_BYTES-1:0]      payload;

    modport src (
        output valid,
        output ip_header,
        output udp_header,
        output payload
    );

    modport dst (
        input valid,
        input ip_header,
        input udp_header,
        input payload
    );

endinterface

// File: design/ip_checksum.sv
`timescale 1ns/1ps

// One registered stage that fills in the IPv4 header checksum
// The UDP header and payload pass through unchanged
module ip_checksum #(
    parameter int DATA_BYTES = 1
) (
    input  logic clk,
    input  logic reset,
    frame_if.dst raw,
    frame_if.src tx
);

    // Ten 16-bit words never need more than 20 bits
    logic [19:0]            word_sum;
    logic [16:0]            fold_once;
    logic [15:0]            fold_twice;
    udp_ip_pkg::ip_header_u header_out;

    always_comb begin
        word_sum = 20'h00000;
        for (int i = 0; i < udp_ip_pkg::IP_HEADER_WORDS; i++) begin
            word_sum = word_sum + 20'(raw.ip_header.words[i]);
        end
    end

    // End-around carry, folded twice
    // After the first fold a carry leaves at most 14 in the low word, so the second cannot carry
    assign fold_once  = 17'(word_sum[15:0]) + 17'(word_sum[19:16]);
    assign fold_twice = fold_once[15:0] + 16'(fold_once[16]);

    always_comb begin
        header_out = raw.ip_header;
        header_out.fields.header_checksum = ~fold_twice;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tx.valid <= 1'b0;
        end else begin
            tx.valid <= raw.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (raw.valid) begin
            tx.ip_header  <= header_out;
            tx.udp_header <= raw.udp_header;
            tx.payload    <= raw.payload;
        end
    end

    // Exactly one cycle of latency through this stage
    assert property (@(posedge clk) disable iff (reset) tx.valid == $past(raw.valid))
        else $error("checksummed frame valid is not the raw valid one cycle later");

endmodule

// File: design/mii_tx_pkg.sv
package mii_tx_pkg;

    // Width of the PHY transmit data bus
    localparam int NIBBLE_BITS = 4;

    // Inter-packet gap in strobe periods
    // Twelve bytes of idle line time at one nibble per strobe
    localparam int GAP_NIBBLES = 24;

    // The strobe is a one-cycle pulse, so it needs at least two clk cycles per period
    localparam int MIN_DIVIDER = 2;

endpackage

// File: design/nibble_serializer.sv
`timescale 1ns/1ps

// Streams a checksummed packet onto the 4-bit PHY bus, one nibble per strobe
// Also owns the strobe divider and times the inter-packet gap
module nibble_serializer #(
    parameter int DATA_BYTES = 1,
    parameter int DIVIDER    = 2
) (
    input  logic                               clk,
    input  logic                               reset,
    frame_if.dst                               tx,
    output logic                               tx_en,
    output logic [mii_tx_pkg::NIBBLE_BITS-1:0] tx_d,
    output logic                               gap_done
);

    localparam int PACKET_BYTES  =
        udp_ip_pkg::IP_HEADER_BYTES + udp_ip_pkg::UDP_HEADER_BYTES + DATA_BYTES;
    localparam int PACKET_BITS   = 8 * PACKET_BYTES;
    localparam int TOTAL_NIBBLES = 2 * PACKET_BYTES;
    localparam int IDX_W         = $clog2(TOTAL_NIBBLES + 1);
    localparam int DIV_W         = $clog2(DIVIDER);
    localparam int GAP_W         = $clog2(mii_tx_pkg::GAP_NIBBLES);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_SEND = 2'd1;
    localparam logic [1:0] ST_GAP  = 2'd2;

    initial begin
        if (DIVIDER < mii_tx_pkg::MIN_DIVIDER) begin
            $error("DIVIDER must be at least %0d", mii_tx_pkg::MIN_DIVIDER);
        end
        if (DATA_BYTES < 1 || DATA_BYTES > udp_ip_pkg::MAX_DATA_BYTES) begin
            $error("DATA_BYTES must lie in 1 to %0d", udp_ip_pkg::MAX_DATA_BYTES);
        end
    end

    logic [DIV_W-1:0]                   div_count;
    logic                               strobe;
    logic [1:0]                         state;
    logic                               pending;
    logic [IDX_W-1:0]                   nib_idx;
    logic [GAP_W-1:0]                   gap_count;
    logic [PACKET_BITS-1:0]             packet;
    logic [7:0]                         cur_byte;
    logic [mii_tx_pkg::NIBBLE_BITS-1:0] next_nibble;

    // Free-running divider, one strobe cycle in every DIVIDER cycles
    always_ff @(posedge clk) begin
        if (reset || div_count == DIV_W'(DIVIDER - 1)) begin
            div_count <= '0;
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    assign strobe = (div_count == DIV_W'(DIVIDER - 1));

    // Wire order is IP header, UDP header, payload, each most significant byte first
    assign packet = {tx.ip_header, tx.udp_header, tx.payload};

    // Picks the nibble that nib_idx points at, low nibble of each byte first
    // Only looked at while nib_idx is inside the packet
    always_comb begin
        cur_byte    = packet[PACKET_BITS - 1 - 8 * nib_idx[IDX_W-1:1] -: 8];
        next_nibble = nib_idx[0] ? cur_byte[7:4] : cur_byte[3:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            pending   <= 1'b0;
            nib_idx   <= '0;
            gap_count <= '0;
            tx_en     <= 1'b0;
            tx_d      <= '0;
            gap_done  <= 1'b0;
        end else begin
            gap_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // Start on the first strobe after the packet was handed over
                    if (pending && strobe) begin
                        pending <= 1'b0;
                        tx_en   <= 1'b1;
                        tx_d    <= next_nibble;
                        nib_idx <= nib_idx + 1'b1;
                        state   <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (strobe) begin
                        if (nib_idx == IDX_W'(TOTAL_NIBBLES)) begin
                            // Last nibble has had its full strobe period
                            tx_en     <= 1'b0;
                            tx_d      <= '0;
                            nib_idx   <= '0;
                            gap_count <= '0;
                            state     <= ST_GAP;
                        end else begin
                            tx_d    <= next_nibble;
                            nib_idx <= nib_idx + 1'b1;
                        end
                    end
                end
                ST_GAP: begin
                    if (strobe) begin
                        if (gap_count == GAP_W'(mii_tx_pkg::GAP_NIBBLES - 1)) begin
                            gap_done <= 1'b1;
                            state    <= ST_IDLE;
                        end else begin
                            gap_count <= gap_count + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
            // Ready upstream keeps this from landing while a packet is still going out
            if (tx.valid) begin
                pending <= 1'b1;
            end
        end
    end

    // tx_en is registered on a strobe, so its rise must follow a strobe cycle
    assert property (@(posedge clk) disable iff (reset) $rose(tx_en) |-> $past(strobe))
        else $error("tx_en rose without a PHY strobe");

endmodule

// File: design/udp_ip_pkg.sv
package udp_ip_pkg;

    // Byte counts of the two headers that precede the UDP payload
    localparam int IP_HEADER_BYTES  = 20;
    localparam int UDP_HEADER_BYTES = 8;

    // The IPv4 header checksum runs over this many 16-bit words
    localparam int IP_HEADER_WORDS = IP_HEADER_BYTES / 2;

    // Fixed IPv4 field values for every packet this transmitter sends
    localparam logic [3:0]  IP_VERSION      = 4'd4;
    localparam logic [3:0]  IP_IHL          = 4'd5;
    localparam logic [7:0]  IP_TOS          = 8'h0C;
    localparam logic [7:0]  IP_TTL          = 8'hFF;
    localparam logic [7:0]  IP_PROTOCOL_UDP = 8'h11;

    // No fragmentation, so identification, flags and offset stay zero
    localparam logic [15:0] IP_IDENT       = 16'h0000;
    localparam logic [2:0]  IP_FLAGS       = 3'b000;
    localparam logic [12:0] IP_FRAG_OFFSET = 13'h0000;

    // Largest payload that fits a 576-byte datagram with a full 60-byte IP header
    localparam int MAX_DATA_BYTES = 508;

    // IPv4 header as in RFC 791, first transmitted field in the top bits
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [7:0]  type_of_service;
        logic [15:0] total_length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  time_to_live;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] src_ip;
        logic [31:0] dest_ip;
    } ip_header_t;

    // The same 160 bits seen as fields or as the ten words that the checksum adds
    // Word 9 is the first word on the wire
    typedef union packed {
        ip_header_t                             fields;
        logic [IP_HEADER_WORDS-1:0][15:0]       words;
    } ip_header_u;

    // UDP header as in RFC 768
    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_header_t;

endpackage

// File: design/udp_tx_top.sv
`timescale 1ns/1ps

// UDP over IPv4 transmitter with a 4-bit MII style transmit port
// Capture, then checksum, then serialize, with one packet in flight at a time
module udp_tx_top #(
    parameter int DATA_BYTES = 32,
    parameter int DIVIDER    = 4
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [8*DATA_BYTES-1:0]            data,
    input  logic [31:0]                        src_ip,
    input  logic [31:0]                        dest_ip,
    input  logic [15:0]                        src_port,
    input  logic [15:0]                        dest_port,
    input  logic                               send,
    output logic                               ready,
    output logic                               tx_en,
    output logic [mii_tx_pkg::NIBBLE_BITS-1:0] tx_d
);

    // Pulses when the serializer has finished the gap after a packet
    logic gap_done;

    // Headers with a zero IP checksum
    frame_if #(.DATA_BYTES(DATA_BYTES)) raw_frame ();
    // Headers with the IP checksum filled in
    frame_if #(.DATA_BYTES(DATA_BYTES)) tx_frame ();

    frame_capture #(
        .DATA_BYTES (DATA_BYTES)
    ) u_frame_capture (
        .clk       (clk),
        .reset     (reset),
        .data      (data),
        .src_ip    (src_ip),
        .dest_ip   (dest_ip),
        .src_port  (src_port),
        .dest_port (dest_port),
        .send      (send),
        .gap_done  (gap_done),
        .ready     (ready),
        .raw       (raw_frame)
    );

    ip_checksum #(
        .DATA_BYTES (DATA_BYTES)
    ) u_ip_checksum (
        .clk   (clk),
        .reset (reset),
        .raw   (raw_frame),
        .tx    (tx_frame)
    );

    nibble_serializer #(
        .DATA_BYTES (DATA_BYTES),
        .DIVIDER    (DIVIDER)
    ) u_nibble_serializer (
        .clk      (clk),
        .reset    (reset),
        .tx       (tx_frame),
        .tx_en    (tx_en),
        .tx_d     (tx_d),
        .gap_done (gap_done)
    );

endmodule

// File: tests/tb_udp_tx.sv
`timescale 1ns/1ps

// Testbench for the UDP transmitter
// Sends random packets with random spacing and noise on send while busy
module tb_udp_tx;

    localparam int DATA_BYTES  = 6;
    localparam int DIVIDER     = 3;
    localparam int NUM_PACKETS = 20;
    // One packet, its gap and some slack for the random waits
    localparam int PACKET_CYCLES  = 2 * (28 + DATA_BYTES) * DIVIDER + 24 * DIVIDER + 60;
    localparam int TIMEOUT_CYCLES = 2 * NUM_PACKETS * PACKET_CYCLES;

    logic                    clk;
    logic                    reset;
    logic [8*DATA_BYTES-1:0] data;
    logic [31:0]             src_ip;
    logic [31:0]             dest_ip;
    logic [15:0]             src_port;
    logic [15:0]             dest_port;
    logic                    send;
    logic                    ready;
    logic                    tx_en;
    logic [3:0]              tx_d;
    int                      value_errors;
    int                      other_errors;
    int                      packets_done;
    int                      run_errors = 0;
    int                      cycle_count = 0;
    integer                  seed;

    udp_tx_top #(
        .DATA_BYTES (DATA_BYTES),
        .DIVIDER    (DIVIDER)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .data      (data),
        .src_ip    (src_ip),
        .dest_ip   (dest_ip),
        .src_port  (src_port),
        .dest_port (dest_port),
        .send      (send),
        .ready     (ready),
        .tx_en     (tx_en),
        .tx_d      (tx_d)
    );

    tb_udp_tx_checker #(
        .DATA_BYTES (DATA_BYTES),
        .DIVIDER    (DIVIDER)
    ) u_checker (
        .clk          (clk),
        .reset        (reset),
        .data         (data),
        .src_ip       (src_ip),
        .dest_ip      (dest_ip),
        .src_port     (src_port),
        .dest_port    (dest_port),
        .send         (send),
        .ready        (ready),
        .tx_en        (tx_en),
        .tx_d         (tx_d),
        .value_errors (value_errors),
        .other_errors (other_errors),
        .packets_done (packets_done)
    );

    always #10 clk = ~clk;

    // Ends a run that stops making progress
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic randomize_inputs();
        for (int i = 0; i < DATA_BYTES; i++) begin
            data[8 * i +: 8] = 8'($random(seed));
        end
        src_ip    = $random(seed);
        dest_ip   = $random(seed);
        src_port  = 16'($random(seed));
        dest_port = 16'($random(seed));
    endtask

    // One real send, then random send pulses or a held send until ready returns
    task automatic run_packet();
        int idle_cycles;
        bit hold_high;
        idle_cycles = 1 + ($unsigned($random(seed)) % 6);
        hold_high = (($unsigned($random(seed)) % 4) == 0);
        send = 1'b0;
        repeat (idle_cycles) next_cycle();
        randomize_inputs();
        send = 1'b1;
        next_cycle();
        while (ready !== 1'b1) begin
            if (!hold_high) begin
                send = 1'($random(seed));
                randomize_inputs();
            end
            next_cycle();
        end
    endtask

    initial begin
        seed = 32'h4177_27d2;
        clk = 1'b0;
        reset = 1'b1;
        send = 1'b0;
        data = '0;
        src_ip = 32'h0;
        dest_ip = 32'h0;
        src_port = 16'h0;
        dest_port = 16'h0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int p = 0; p < NUM_PACKETS; p++) begin
            run_packet();
        end
        send = 1'b0;
        repeat (4) next_cycle();
        if (packets_done != NUM_PACKETS) begin
            run_errors++;
            $display("Expected %0d complete packets on the PHY port, saw %0d",
                     NUM_PACKETS, packets_done);
        end
        $display("Closing report: %0d wrong values, %0d other errors, %0d packets",
                 value_errors, other_errors + run_errors, packets_done);
        if (value_errors == 0 && other_errors == 0 && run_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: tests/tb_udp_tx_checker.sv
`timescale 1ns/1ps

// Watches the DUT ports, runs a reference model of the transmitter and compares
// All ports are sampled on the rising clock edge, where the stimulus is stable
module tb_udp_tx_checker #(
    parameter int DATA_BYTES = 6,
    parameter int DIVIDER    = 3
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [8*DATA_BYTES-1:0] data,
    input  logic [31:0]             src_ip,
    input  logic [31:0]             dest_ip,
    input  logic [15:0]             src_port,
    input  logic [15:0]             dest_port,
    input  logic                    send,
    input  logic                    ready,
    input  logic                    tx_en,
    input  logic [3:0]              tx_d,
    output int                      value_errors,
    output int                      other_errors,
    output int                      packets_done
);

    // 20 bytes of IPv4 header and 8 of UDP header ahead of the payload
    localparam int PACKET_BYTES = 28 + DATA_BYTES;
    localparam int NIBBLES      = 2 * PACKET_BYTES;
    localparam int GAP_CYCLES   = 24 * DIVIDER;

    localparam int PH_IDLE = 0;
    localparam int PH_WAIT = 1;
    localparam int PH_SEND = 2;
    localparam int PH_GAP  = 3;

    int         value_count = 0;
    int         other_count = 0;
    int         done_count = 0;
    int         reset_cycles = 0;
    int         cyc = 0;
    int         phase = PH_IDLE;
    int         wait_count = 0;
    int         nib_i = 0;
    int         hold = 0;
    int         ready_due = 0;
    logic       prev_send = 1'b1;
    logic       exp_ready = 1'b1;
    logic       send_edge;
    logic [3:0] exp_nib [NIBBLES];

    assign value_errors = value_count;
    assign other_errors = other_count;
    assign packets_done = done_count;

    // Expected wire stream for the inputs present at an accepted send edge
    task automatic build_stream();
        logic [7:0]  pkt [PACKET_BYTES];
        logic [15:0] total_len;
        logic [15:0] udp_len;
        logic [31:0] sum;
        logic [15:0] csum;
        total_len = 16'(PACKET_BYTES);
        udp_len = 16'(8 + DATA_BYTES);
        for (int i = 0; i < PACKET_BYTES; i++) begin
            pkt[i] = 8'h00;
        end
        // Version 4, IHL 5, TOS 0C, TTL FF, protocol 11, no fragmentation
        pkt[0] = 8'h45;
        pkt[1] = 8'h0C;
        pkt[2] = total_len[15:8];
        pkt[3] = total_len[7:0];
        pkt[8] = 8'hFF;
        pkt[9] = 8'h11;
        for (int i = 0; i < 4; i++) begin
            pkt[12 + i] = src_ip[31 - 8 * i -: 8];
            pkt[16 + i] = dest_ip[31 - 8 * i -: 8];
        end
        pkt[20] = src_port[15:8];
        pkt[21] = src_port[7:0];
        pkt[22] = dest_port[15:8];
        pkt[23] = dest_port[7:0];
        pkt[24] = udp_len[15:8];
        pkt[25] = udp_len[7:0];
        // UDP checksum bytes 26 and 27 stay zero
        for (int i = 0; i < DATA_BYTES; i++) begin
            pkt[28 + i] = data[8 * (DATA_BYTES - 1 - i) +: 8];
        end
        // Ones' complement sum of the ten header words, carries folded back in
        sum = 32'h0;
        for (int w = 0; w < 10; w++) begin
            sum = sum + {16'h0, pkt[2 * w], pkt[2 * w + 1]};
        end
        while (sum[31:16] != 16'h0) begin
            sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
        end
        csum = ~sum[15:0];
        pkt[10] = csum[15:8];
        pkt[11] = csum[7:0];
        // Low nibble of each byte goes out first
        for (int j = 0; j < PACKET_BYTES; j++) begin
            exp_nib[2 * j]     = pkt[j][3:0];
            exp_nib[2 * j + 1] = pkt[j][7:4];
        end
    endtask

    // Compares tx_en and tx_d with where the model says the packet should be
    task automatic follow_tx();
        case (phase)
            PH_WAIT: begin
                wait_count++;
                if (tx_en === 1'b1) begin
                    // Pipeline takes three cycles, then the next strobe starts the packet
                    if (wait_count < 4 || wait_count > DIVIDER + 3) begin
                        other_count++;
                        $display("tx_en rose %0d cycles after the accepted send, outside %0d to %0d",
                                 wait_count, 4, DIVIDER + 3);
                    end
                    nib_i = 0;
                    hold = 0;
                    phase = PH_SEND;
                end else if (wait_count == DIVIDER + 4) begin
                    other_count++;
                    $display("tx_en did not rise after an accepted send at cycle %0d", cyc);
                end
            end
            PH_GAP, PH_IDLE: begin
                if (tx_en !== 1'b0) begin
                    value_count++;
                    $display("[FAIL] tx_en: got %h expected 0 at cycle %0d", tx_en, cyc);
                end
                if (tx_d !== 4'h0) begin
                    value_count++;
                    $display("[FAIL] tx_d: got %h expected 0 at cycle %0d", tx_d, cyc);
                end
            end
            default: begin
            end
        endcase
        if (phase == PH_SEND) begin
            if (hold == DIVIDER) begin
                nib_i++;
                hold = 0;
            end
            if (nib_i == NIBBLES) begin
                if (tx_en !== 1'b0) begin
                    value_count++;
                    $display("[FAIL] tx_en: got %h expected 0 after %0d nibbles", tx_en, NIBBLES);
                end
                // Ready comes back after the gap strobes plus one registered cycle
                phase = PH_GAP;
                ready_due = cyc + GAP_CYCLES;
            end else begin
                if (tx_en !== 1'b1) begin
                    value_count++;
                    $display("[FAIL] tx_en: got %h expected 1 at nibble %0d", tx_en, nib_i);
                end
                if (tx_d !== exp_nib[nib_i]) begin
                    value_count++;
                    $display("[FAIL] tx_d: got %h expected %h at nibble %0d of packet %0d",
                             tx_d, exp_nib[nib_i], nib_i, done_count);
                end
                hold++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            // The first reset edge has not loaded the registers yet
            if (reset_cycles > 0 && (ready !== 1'b1 || tx_en !== 1'b0)) begin
                value_count++;
                $display("[FAIL] ready/tx_en in reset: got %h/%h expected 1/0", ready, tx_en);
            end
            reset_cycles++;
            prev_send = 1'b1;
            exp_ready = 1'b1;
            phase = PH_IDLE;
        end else begin
            cyc++;
            if (ready !== exp_ready) begin
                value_count++;
                $display("[FAIL] ready: got %h expected %h at cycle %0d", ready, exp_ready, cyc);
            end
            follow_tx();
            // Model update for this edge, using the inputs sampled here
            send_edge = send & ~prev_send;
            prev_send = send;
            if (send_edge && exp_ready) begin
                exp_ready = 1'b0;
                build_stream();
                phase = PH_WAIT;
                wait_count = 0;
            end else if (phase == PH_GAP && cyc == ready_due) begin
                exp_ready = 1'b1;
                phase = PH_IDLE;
                done_count++;
            end
        end
    end

endmodule

// File: udp_tx.f
design/udp_ip_pkg.sv
design/mii_tx_pkg.sv
design/frame_if.sv
design/frame_capture.sv
design/ip_checksum.sv
design/nibble_serializer.sv
design/udp_tx_top.sv
tests/tb_udp_tx_checker.sv
tests/tb_udp_tx.sv
